// File: bench/core_tests.txt
// First word is the number of tests, then one test per line:
// insn pc undefined write_reg rd value flags(nzcv) branch_target
1d
E3A01005 00000000 0 1 1 00000005 0 00000000
E3B024FF 00000004 0 1 2 FF000000 A 00000000
E0923002 00000008 0 1 3 FE000000 A 00000000
E2A14010 0000000C 0 1 4 00000016 A 00000000
E3510005 00000010 0 0 0 00000000 6 00000000
E0415104 00000014 0 1 5 FFFFFFAD 6 00000000
E2616020 00000018 0 1 6 0000001B 6 00000000
E0267225 0000001C 0 1 7 0FFFFFE1 6 00000000
E21780FF 00000020 0 1 8 000000E1 2 00000000
E18890C1 00000024 0 1 9 000000E3 2 00000000
E3C9A003 00000028 0 1 A 000000E0 2 00000000
E3F0B000 0000002C 0 1 B FFFFFFFF A 00000000
E3110004 00000030 0 0 0 00000000 2 00000000
E00C0691 00000034 0 1 C 00000087 2 00000000
E01D0195 00000038 0 1 D FFFFFE61 A 00000000
E5819013 0000003C 0 0 0 00000000 A 00000000
E5940002 00000040 0 1 0 000000E3 A 00000000
E0803000 00000044 0 1 3 000001C6 A 00000000
E50C3063 00000048 0 0 0 00000000 A 00000000
E5962009 0000004C 0 1 2 000001C6 A 00000000
EA000010 00000050 0 0 0 00000000 A 00000098
EBFFFFFC 00000054 0 1 E 00000058 A 0000004C
03A01077 00000058 0 0 0 00000000 A 00000000
03510005 0000005C 0 0 0 00000000 A 00000000
42812001 00000060 0 1 2 00000006 A 00000000
E0811312 00000064 1 0 0 00000000 A 00000000
E5D41002 00000068 1 0 0 00000000 A 00000000
EF000000 0000006C 1 0 0 00000000 A 00000000
E0813002 00000070 0 1 3 0000000B A 00000000

// File: src.f
design/core_pkg.sv
design/decode_data.sv
design/decode_ldst.sv
design/decode_mux.sv
design/pipe_stage.sv
design/core_execute.sv
design/core_result.sv
design/core_top.sv
bench/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f src.f --top-module core_tb -o core_sim \
	&& ./obj_dir/core_sim | tee sim.log \
	|| echo "Build or simulation stopped with an error"
test -f sim.log || exit 1
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || exit 1
echo "Simulation passed"

// File: bench/core_tb.sv
`timescale 1ns/100ps

module core_tb import core_pkg::*; ();

	localparam int FIELDS    = 8;
	localparam int MAX_TESTS = 64;
	localparam int TIMEOUT   = 100;

	logic     clk;
	logic     rst;
	word      insn;
	word      insn_pc;
	logic     insn_valid;
	logic     insn_ready;
	logic     ret_valid;
	logic     ret_ready;
	word      ret_pc;
	reg_num   ret_rd;
	word      ret_value;
	logic     ret_write_reg;
	psr_flags ret_flags;
	logic     ret_undefined;
	word      ret_branch_target;

	// Word 0 is the test count, then FIELDS words per test.
	word         test_mem [FIELDS*MAX_TESTS+1];
	int          test_count;
	int          cur_test;
	logic [15:0] ready_lfsr;

	core_top dut_i (
		.clk, .rst, .insn, .insn_pc, .insn_valid, .insn_ready,
		.ret_valid, .ret_ready, .ret_pc, .ret_rd, .ret_value, .ret_write_reg,
		.ret_flags, .ret_undefined, .ret_branch_target
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_step(logic [15:0] state);
		return (state >> 1) ^ (state[0] ? 16'hb400 : 16'h0000);
	endfunction

	// Random back-pressure on the retire port.
	initial begin
		ready_lfsr = 16'd48;
		ret_ready = 1'b0;
		forever begin
			@(posedge clk);
			ret_ready <= ready_lfsr[0];
			ready_lfsr <= lfsr_step(ready_lfsr);
		end
	end

	// ####################
	// Checks and waits.
	task automatic stop_with_failure();
		$display("Done: errors found");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic check_value(string what, word got, word expected);
		if (got !== expected) begin
			$display("[FAIL] %0t ns: test %0d, %s is %08h, expected %08h",
				$time, cur_test, what, got, expected);
			stop_with_failure();
		end
	endtask

	task automatic wait_for_accept(int idx);
		int waits;
		waits = 0;
		do begin
			@(negedge clk);
			waits++;
			if (waits > TIMEOUT) begin
				$display("Timeout: instruction %0d was never accepted", idx);
				stop_with_failure();
			end
		end while (!insn_ready);
	endtask

	task automatic wait_for_retire(int idx);
		int waits;
		waits = 0;
		do begin
			@(negedge clk);
			waits++;
			if (waits > TIMEOUT) begin
				$display("Timeout: instruction %0d never retired", idx);
				stop_with_failure();
			end
		end while (!(ret_valid && ret_ready));
	endtask

	// ####################
	// Driver and checker.
	task automatic drive_all();
		int i;
		for (i = 0; i < test_count; i++) begin
			insn <= test_mem[1 + i*FIELDS];
			insn_pc <= test_mem[2 + i*FIELDS];
			insn_valid <= 1'b1;
			wait_for_accept(i);
			@(posedge clk);
		end
		insn_valid <= 1'b0;
	endtask

	task automatic check_all();
		int i;
		int base;
		@(negedge clk);
		cur_test = -1;
		check_value("insn_ready after reset", {31'd0, insn_ready}, 32'd1);
		check_value("ret_valid after reset", {31'd0, ret_valid}, 32'd0);
		for (i = 0; i < test_count; i++) begin
			base = 1 + i*FIELDS;
			cur_test = i;
			wait_for_retire(i);
			check_value("pc", ret_pc, test_mem[base + 1]);
			check_value("undefined", {31'd0, ret_undefined}, test_mem[base + 2]);
			check_value("write_reg", {31'd0, ret_write_reg}, test_mem[base + 3]);
			// Rd and value mean something only when a register is written.
			if (test_mem[base + 3] != 0) begin
				check_value("rd", {28'd0, ret_rd}, test_mem[base + 4]);
				check_value("value", ret_value, test_mem[base + 5]);
			end
			check_value("flags", {28'd0, ret_flags}, test_mem[base + 6]);
			check_value("branch target", ret_branch_target, test_mem[base + 7]);
		end
	endtask

	initial begin
		rst = 1'b1;
		insn = '0;
		insn_pc = '0;
		insn_valid = 1'b0;
		cur_test = -1;
		$readmemh("bench/core_tests.txt", test_mem);
		test_count = test_mem[0];
		if (test_count == 0 || test_count > MAX_TESTS) begin
			$display("Test file is missing, empty or holds too many tests");
			stop_with_failure();
		end

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		fork
			drive_all();
			check_all();
		join

		$display("Done: no errors");
		$finish;
	end

endmodule

// File: design/core_top.sv
`timescale 1ns/100ps

module core_top import core_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  word      insn,
	input  word      insn_pc,
	input  logic     insn_valid,
	output logic     insn_ready,
	output logic     ret_valid,
	input  logic     ret_ready,
	output word      ret_pc,
	output reg_num   ret_rd,
	output word      ret_value,
	output logic     ret_write_reg,
	output psr_flags ret_flags,
	output logic     ret_undefined,
	output word      ret_branch_target
);

	snd_decode    snd;
	data_decode   data;
	ldst_decode   ldst_single;
	logic         data_update_flags, data_writeback, snd_undefined;
	logic         ldst_single_is_imm, ldst_undefined;
	reg_num       mul_rd, mul_rs, mul_rm;
	exec_bundle   dec_bundle, exe_bundle;
	retire_bundle exe_result, ret_item;
	logic         exe_valid, exe_ready, ret_item_valid, ret_item_ready;
	reg_num       raddr_n, raddr_m, raddr_s;
	word          rdata_n, rdata_m, rdata_s, load_data;
	psr_flags     flags;

	decode_data decode_data_i (
		.insn, .snd, .data, .data_update_flags, .data_writeback, .snd_undefined,
		.mul_rd, .mul_rs, .mul_rm
	);

	decode_ldst decode_ldst_i (.insn, .ldst_single, .ldst_single_is_imm, .ldst_undefined);

	decode_mux decode_mux_i (
		.insn, .insn_pc, .snd, .snd_undefined, .data, .data_writeback, .data_update_flags,
		.mul_rd, .mul_rs, .mul_rm, .ldst_single, .ldst_single_is_imm, .ldst_undefined,
		.bundle(dec_bundle)
	);

	pipe_stage #(.payload_t(exec_bundle)) dec_stage (
		.clk, .rst, .in_valid(insn_valid), .in_ready(insn_ready), .in_data(dec_bundle),
		.out_valid(exe_valid), .out_ready(exe_ready), .out_data(exe_bundle)
	);

	core_execute core_execute_i (
		.bundle(exe_bundle), .reg_rdata_n(rdata_n), .reg_rdata_m(rdata_m),
		.reg_rdata_s(rdata_s), .reg_raddr_n(raddr_n), .reg_raddr_m(raddr_m),
		.reg_raddr_s(raddr_s), .fwd(ret_item), .fwd_valid(ret_item_valid),
		.fwd_load_data(load_data), .flags, .result(exe_result)
	);

	pipe_stage #(.payload_t(retire_bundle)) ret_stage (
		.clk, .rst, .in_valid(exe_valid), .in_ready(exe_ready), .in_data(exe_result),
		.out_valid(ret_item_valid), .out_ready(ret_item_ready), .out_data(ret_item)
	);

	core_result core_result_i (
		.clk, .rst, .item(ret_item), .item_valid(ret_item_valid), .item_ready(ret_item_ready),
		.reg_raddr_n(raddr_n), .reg_raddr_m(raddr_m), .reg_raddr_s(raddr_s),
		.reg_rdata_n(rdata_n), .reg_rdata_m(rdata_m), .reg_rdata_s(rdata_s),
		.flags, .load_data, .ret_valid, .ret_ready, .ret_pc, .ret_rd, .ret_value,
		.ret_write_reg, .ret_flags, .ret_undefined, .ret_branch_target
	);

endmodule

// File: design/core_result.sv
`timescale 1ns/100ps

module core_result import core_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  retire_bundle item,
	input  logic         item_valid,
	output logic         item_ready,
	input  reg_num       reg_raddr_n,
	input  reg_num       reg_raddr_m,
	input  reg_num       reg_raddr_s,
	output word          reg_rdata_n,
	output word          reg_rdata_m,
	output word          reg_rdata_s,
	output psr_flags     flags,
	output word          load_data,
	output logic         ret_valid,
	input  logic         ret_ready,
	output word          ret_pc,
	output reg_num       ret_rd,
	output word          ret_value,
	output logic         ret_write_reg,
	output psr_flags     ret_flags,
	output logic         ret_undefined,
	output word          ret_branch_target
);

	word  regs [REG_COUNT];
	word  mem [MEM_WORDS];
	logic commit;

	assign reg_rdata_n = regs[reg_raddr_n];
	assign reg_rdata_m = regs[reg_raddr_m];
	assign reg_rdata_s = regs[reg_raddr_s];

	// Loads pick up their data here, one stage after the address.
	assign load_data = mem[item.mem_addr];
	assign commit = item_valid && ret_ready;

	assign item_ready = ret_ready;
	assign ret_valid = item_valid;
	assign ret_pc = item.pc;
	assign ret_rd = item.rd;
	assign ret_value = item.load ? load_data : item.value;
	assign ret_write_reg = item.write_reg;
	assign ret_flags = item.new_flags;
	assign ret_undefined = item.undefined;
	assign ret_branch_target = item.branch_target;

	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (commit) begin
			if (item.write_reg)
				regs[item.rd] <= ret_value;
			if (item.update_flags)
				flags <= item.new_flags;
		end
	end

	always_ff @(posedge clk) begin
		if (commit && item.write_mem)
			mem[item.mem_addr] <= item.store_data;
	end

endmodule

// File: design/core_execute.sv
`timescale 1ns/100ps

module core_execute import core_pkg::*; (
	input  exec_bundle   bundle,
	input  word          reg_rdata_n,
	input  word          reg_rdata_m,
	input  word          reg_rdata_s,
	output reg_num       reg_raddr_n,
	output reg_num       reg_raddr_m,
	output reg_num       reg_raddr_s,
	input  retire_bundle fwd,
	input  logic         fwd_valid,
	input  word          fwd_load_data,
	input  psr_flags     flags,
	output retire_bundle result
);

	word         pc8, op_n, op_m, op_s, a, shifted, alu_res, product, addr;
	word         sum_x, sum_y;
	logic [32:0] sum;
	logic [63:0] dbl;
	logic [4:0]  sh, rot;
	logic        shift_c, sum_ci, logic_op, passed, exec_ok;
	psr_flags    cur, alu_flags, mul_flags;

	function automatic word operand(reg_num addr_r, word rdata);
		if (addr_r == R15)
			return pc8;
		else if (fwd_valid && fwd.write_reg && fwd.rd == addr_r)
			return fwd.load ? fwd_load_data : fwd.value;
		return rdata;
	endfunction

	function automatic logic cond_pass(logic [3:0] cond, psr_flags f);
		case (cond)
			4'h0: return f.z;
			4'h1: return !f.z;
			4'h2: return f.c;
			4'h3: return !f.c;
			4'h4: return f.n;
			4'h5: return !f.n;
			4'h6: return f.v;
			4'h7: return !f.v;
			4'h8: return f.c && !f.z;
			4'h9: return !f.c || f.z;
			4'ha: return f.n == f.v;
			4'hb: return f.n != f.v;
			4'hc: return !f.z && f.n == f.v;
			4'hd: return f.z || f.n != f.v;
			default: return 1'b1;
		endcase
	endfunction

	// ####################
	// Operands and condition.
	assign pc8 = bundle.pc + 32'd8;
	assign reg_raddr_n = bundle.data.rn;
	assign reg_raddr_m = bundle.snd.r;
	assign reg_raddr_s = bundle.data.rd;

	always_comb begin
		op_n = operand(reg_raddr_n, reg_rdata_n);
		op_m = operand(reg_raddr_m, reg_rdata_m);
		op_s = operand(reg_raddr_s, reg_rdata_s);
		cur = (fwd_valid && fwd.update_flags) ? fwd.new_flags : flags;
		passed = !bundle.conditional || cond_pass(bundle.cond, cur);
	end

	// ####################
	// Shifter.
	always_comb begin
		sh = bundle.snd.shift_imm;
		rot = {bundle.snd.imm[11:8], 1'b0};
		dbl = {op_m, op_m} >> sh;
		shifted = op_m;
		shift_c = cur.c;

		if (bundle.snd.is_imm && bundle.snd.ror) begin
			dbl = {24'd0, bundle.snd.imm[7:0], 24'd0, bundle.snd.imm[7:0]} >> rot;
			shifted = dbl[31:0];
			if (rot != 5'd0)
				shift_c = shifted[31];
		end else if (bundle.snd.is_imm) begin
			shifted = {20'd0, bundle.snd.imm};
		end else if (sh == 5'd0) begin
			// Zero amount stands for LSR #32, ASR #32 and RRX.
			case (bundle.snd.shift_type)
				SHIFT_LSR: {shifted, shift_c} = {32'd0, op_m[31]};
				SHIFT_ASR: {shifted, shift_c} = {{32{op_m[31]}}, op_m[31]};
				SHIFT_ROR: {shifted, shift_c} = {cur.c, op_m};
				default: ;
			endcase
		end else begin
			case (bundle.snd.shift_type)
				SHIFT_LSL: {shift_c, shifted} = {1'b0, op_m} << sh;
				SHIFT_LSR: {shifted, shift_c} = {op_m, 1'b0} >> sh;
				SHIFT_ASR: {shifted, shift_c} = $signed({op_m, 1'b0}) >>> sh;
				default: {shift_c, shifted} = {dbl[31], dbl[31:0]};
			endcase
		end
	end

	// ####################
	// ALU and multiplier.
	always_comb begin
		a = bundle.data.uses_rn ? op_n : '0;
		sum_x = a;
		sum_y = shifted;
		sum_ci = 1'b0;
		case (bundle.data.op)
			ALU_SUB, ALU_CMP: begin
				sum_y = ~shifted;
				sum_ci = 1'b1;
			end
			ALU_RSB: begin
				sum_x = shifted;
				sum_y = ~a;
				sum_ci = 1'b1;
			end
			ALU_ADC: sum_ci = cur.c;
			default: ;
		endcase
		sum = {1'b0, sum_x} + {1'b0, sum_y} + {32'd0, sum_ci};

		logic_op = 1'b1;
		case (bundle.data.op)
			ALU_AND, ALU_TST: alu_res = a & shifted;
			ALU_EOR: alu_res = a ^ shifted;
			ALU_ORR: alu_res = a | shifted;
			ALU_MOV: alu_res = shifted;
			ALU_BIC: alu_res = a & ~shifted;
			ALU_MVN: alu_res = ~shifted;
			default: begin
				alu_res = sum[31:0];
				logic_op = 1'b0;
			end
		endcase

		alu_flags.n = alu_res[31];
		alu_flags.z = alu_res == '0;
		alu_flags.c = logic_op ? shift_c : sum[32];
		alu_flags.v = logic_op ? cur.v : sum_x[31] == sum_y[31] && sum[31] != sum_x[31];

		// Low half only, C and V are left alone.
		product = op_n * op_m;
		mul_flags.n = product[31];
		mul_flags.z = product == '0;
		mul_flags.c = cur.c;
		mul_flags.v = cur.v;
	end

	always_comb begin
		exec_ok = bundle.execute && passed;
		addr = bundle.ldst.pre ? alu_res : op_n;

		result.pc = bundle.pc;
		result.rd = bundle.data.rd;
		result.write_reg = exec_ok && bundle.writeback;
		result.load = exec_ok && bundle.ldst_en && bundle.ldst.load;
		result.write_mem = exec_ok && bundle.ldst_en && !bundle.ldst.load;
		result.value = '0;
		if (result.write_reg && !result.load)
			result.value = bundle.mul ? product : alu_res;
		result.store_data = op_s;
		result.mem_addr = addr[MEM_AW+1:2];
		result.update_flags = exec_ok && bundle.update_flags;
		result.new_flags = cur;
		if (result.update_flags)
			result.new_flags = bundle.mul ? mul_flags : alu_flags;
		result.undefined = bundle.undefined;
		result.branch_target = '0;
		if (exec_ok && bundle.branch)
			result.branch_target = pc8 + {{6{bundle.offset[23]}}, bundle.offset, 2'b00};
	end

endmodule

// File: design/pipe_stage.sv
`timescale 1ns/100ps

module pipe_stage #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,
	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	// Slot is free when empty or when its item leaves this cycle.
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (rst)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			out_data <= in_data;
	end

endmodule

// File: design/decode_mux.sv
`timescale 1ns/100ps

module decode_mux import core_pkg::*; (
	input  word        insn,
	input  word        insn_pc,
	input  snd_decode  snd,
	input  logic       snd_undefined,
	input  data_decode data,
	input  logic       data_writeback,
	input  logic       data_update_flags,
	input  reg_num     mul_rd,
	input  reg_num     mul_rs,
	input  reg_num     mul_rm,
	input  ldst_decode ldst_single,
	input  logic       ldst_single_is_imm,
	input  logic       ldst_undefined,
	output exec_bundle bundle
);

	logic [11:0] group;
	logic        branch_link;
	logic        bad_alu;

	always_comb begin
		group = {insn[27:20], insn[7:4]};
		branch_link = insn[24];

		// Carry-in forms, TEQ, CMN and the PSR transfers hiding under compares.
		bad_alu = data.op inside {ALU_SBC, ALU_RSC, ALU_TEQ, ALU_CMN}
			|| (!data_writeback && !data_update_flags);

		bundle = '0;
		bundle.cond = insn[31:28];
		bundle.pc = insn_pc;
		bundle.offset = insn[23:0];
		bundle.execute = 1'b1;
		bundle.conditional = insn[31:28] != COND_AL;
		bundle.data.op = ALU_MOV;
		bundle.data.uses_rn = 1'b1;
		bundle.snd.is_imm = 1'b1;

		// Multiply must match before the ALU pattern that covers it.
		priority casez (group)
			12'b101?_????_????: begin
				bundle.branch = 1'b1;
				bundle.data.uses_rn = branch_link;

				if (branch_link) begin
					bundle.data.op = ALU_SUB;
					bundle.data.rd = R14;
					bundle.data.rn = R15;
					bundle.snd.imm = 12'd4;
					bundle.writeback = 1'b1;
				end
			end

			12'b0000_00??_1001: begin
				bundle.mul = 1'b1;
				bundle.data.rd = mul_rd;
				bundle.data.rn = mul_rs;
				bundle.snd.is_imm = 1'b0;
				bundle.snd.r = mul_rm;
				bundle.writeback = 1'b1;
				bundle.update_flags = insn[20];
				// no accumulate
				bundle.undefined = insn[21];
			end

			12'b00??_????_????: begin
				bundle.snd = snd;
				bundle.data = data;
				bundle.writeback = data_writeback;
				bundle.update_flags = data_update_flags;
				bundle.undefined = snd_undefined || bad_alu;
			end

			12'b01??_????_????: begin
				bundle.ldst_en = 1'b1;
				bundle.ldst = ldst_single;
				bundle.snd = snd;
				bundle.snd.is_imm = ldst_single_is_imm;
				bundle.snd.ror = 1'b0;
				bundle.data.op = ldst_single.up ? ALU_ADD : ALU_SUB;
				bundle.data.rd = data.rd;
				bundle.data.rn = data.rn;
				bundle.writeback = ldst_single.load;
				bundle.undefined = ldst_undefined;
			end

			default:
				bundle.undefined = 1'b1;
		endcase

		if (insn[31:28] == COND_NV)
			bundle.undefined = 1'b1;

		if (bundle.undefined) begin
			bundle.execute = 1'b0;
			bundle.writeback = 1'b0;
			bundle.update_flags = 1'b0;
			bundle.branch = 1'b0;
			bundle.ldst_en = 1'b0;
			bundle.mul = 1'b0;
		end
	end

endmodule

// File: design/decode_ldst.sv
`timescale 1ns/100ps

module decode_ldst import core_pkg::*; (
	input  word        insn,
	output ldst_decode ldst_single,
	output logic       ldst_single_is_imm,
	output logic       ldst_undefined
);

	logic byte_xfer;
	logic media;

	always_comb begin
		ldst_single.pre = insn[24];
		ldst_single.up = insn[23];
		ldst_single.writeback = insn[21];
		ldst_single.load = insn[20];

		byte_xfer = insn[22];
		// Register offset with bit 4 set is not a transfer at all.
		media = insn[25] && insn[4];

		// I bit has the opposite sense to data processing.
		ldst_single_is_imm = !insn[25];

		// Word, pre-indexed, no writeback only.
		ldst_undefined = byte_xfer || !ldst_single.pre || ldst_single.writeback || media;
	end

endmodule

// File: design/decode_data.sv
`timescale 1ns/100ps

module decode_data import core_pkg::*; (
	input  word        insn,
	output snd_decode  snd,
	output data_decode data,
	output logic       data_update_flags,
	output logic       data_writeback,
	output logic       snd_undefined,
	output reg_num     mul_rd,
	output reg_num     mul_rs,
	output reg_num     mul_rm
);

	alu_op op;

	always_comb begin
		op = alu_op'(insn[24:21]);

		data.op = op;
		data.rd = insn[15:12];
		data.rn = insn[19:16];
		// MOV and MVN take only the second operand.
		data.uses_rn = op != ALU_MOV && op != ALU_MVN;

		// Opcodes 10xx only set flags.
		data_writeback = insn[24:23] != 2'b10;
		data_update_flags = insn[20];
	end

	always_comb begin
		snd.r = insn[3:0];
		snd.imm = insn[11:0];
		snd.is_imm = insn[25];
		snd.ror = insn[25];
		snd.shift_type = insn[6:5];
		snd.shift_imm = insn[11:7];

		// Bit 4 set on a register operand means shift by register.
		snd_undefined = !insn[25] && insn[4];
	end

	// Multiply keeps rd where data processing has rn.
	assign mul_rd = insn[19:16];
	assign mul_rs = insn[11:8];
	assign mul_rm = insn[3:0];

endmodule

// File: design/core_pkg.sv
package core_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;

	localparam int REG_COUNT = 16;
	localparam int MEM_WORDS = 64;
	localparam int MEM_AW    = $clog2(MEM_WORDS);

	localparam reg_num R14 = 4'd14;
	localparam reg_num R15 = 4'd15;

	localparam logic [3:0] COND_AL = 4'b1110;
	localparam logic [3:0] COND_NV = 4'b1111;

	localparam logic [1:0] SHIFT_LSL = 2'b00;
	localparam logic [1:0] SHIFT_LSR = 2'b01;
	localparam logic [1:0] SHIFT_ASR = 2'b10;
	localparam logic [1:0] SHIFT_ROR = 2'b11;

	// ####################
	// Data processing opcodes, as encoded in bits 24:21.
	typedef enum logic [3:0] {
		ALU_AND = 4'h0, ALU_EOR = 4'h1, ALU_SUB = 4'h2, ALU_RSB = 4'h3,
		ALU_ADD = 4'h4, ALU_ADC = 4'h5, ALU_SBC = 4'h6, ALU_RSC = 4'h7,
		ALU_TST = 4'h8, ALU_TEQ = 4'h9, ALU_CMP = 4'ha, ALU_CMN = 4'hb,
		ALU_ORR = 4'hc, ALU_MOV = 4'hd, ALU_BIC = 4'he, ALU_MVN = 4'hf
	} alu_op;

	typedef struct packed {
		reg_num      r;
		logic [11:0] imm;
		logic        is_imm;
		logic        ror;
		logic [1:0]  shift_type;
		logic [4:0]  shift_imm;
	} snd_decode;

	typedef struct packed {
		alu_op  op;
		reg_num rd;
		reg_num rn;
		logic   uses_rn;
	} data_decode;

	typedef struct packed {
		logic load;
		logic up;
		logic pre;
		logic writeback;
	} ldst_decode;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	// ####################
	// Stage payloads.
	typedef struct packed {
		logic [3:0]  cond;
		word         pc;
		logic [23:0] offset;
		snd_decode   snd;
		data_decode  data;
		ldst_decode  ldst;
		logic        undefined;
		logic        execute;
		logic        conditional;
		logic        writeback;
		logic        update_flags;
		logic        branch;
		logic        ldst_en;
		logic        mul;
	} exec_bundle;

	typedef struct packed {
		word               pc;
		reg_num            rd;
		word               value;
		word               store_data;
		logic [MEM_AW-1:0] mem_addr;
		logic              write_reg;
		logic              write_mem;
		logic              load;
		logic              update_flags;
		logic              undefined;
		psr_flags          new_flags;
		word               branch_target;
	} retire_bundle;

endpackage
